//--- hw/soc_defs.svh
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// clock cycles per microsecond
`define FMAX_MHZ 18

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 8

// byte entries, keep a power of two
`define TX_FIFO_DEPTH 4

// occupancy count must hold the value DEPTH itself
`define TX_FIFO_CNT_W ($clog2(`TX_FIFO_DEPTH) + 1)

// uart
`define ADDR_UART_TX     32'hf000_0000
`define ADDR_UART_STAT   32'hf000_0004

// counters, 64-bit as lo/hi word pairs
`define ADDR_CYCLE_LO    32'hf000_0010
`define ADDR_CYCLE_HI    32'hf000_0014
`define ADDR_MTIME_LO    32'hf000_0018
`define ADDR_MTIME_HI    32'hf000_001c
`define ADDR_MTIMECMP_LO 32'hf000_0020
`define ADDR_MTIMECMP_HI 32'hf000_0024

// general purpose and exit
`define ADDR_GP          32'hf000_0030
`define ADDR_EXIT        32'hf000_0034

`endif

//--- hw/soc_pkg.sv
package soc_pkg;

    // upper and lower words of a timer register
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } timer_halves_t;

    // full view for increment and compare, halves for bus access
    typedef union packed {
        logic [63:0]   full;
        timer_halves_t halves;
    } timer_word_u;

endpackage

//--- hw/timer_unit.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module timer_unit (
    input  logic                clkConstrained,
    input  logic                rst,
    input  logic                cmp_lo_wr,
    input  logic                cmp_hi_wr,
    input  logic [31:0]         cmp_wdata,
    output soc_pkg::timer_word_u cycle,
    output soc_pkg::timer_word_u mtime,
    output soc_pkg::timer_word_u mtimecmp,
    output logic                timer_irq
);

    localparam int PRESC_W = ($clog2(`FMAX_MHZ) > 0) ? $clog2(`FMAX_MHZ) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`FMAX_MHZ - 1);

    logic [PRESC_W-1:0] presc;
    logic               usec_tick;

    assign usec_tick = (presc == PRESC_LAST);

    // free-running clock counter
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            cycle.full <= 64'd0;
        end else begin
            cycle.full <= cycle.full + 64'd1;
        end
    end

    // divide the clock down to one tick per microsecond
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            presc <= '0;
        end else if (usec_tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            mtime.full <= 64'd0;
        end else if (usec_tick) begin
            mtime.full <= mtime.full + 64'd1;
        end
    end

    // compare register, written one word at a time
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            mtimecmp.full <= 64'd0;
        end else begin
            if (cmp_lo_wr) begin
                mtimecmp.halves.lo <= cmp_wdata;
            end
            if (cmp_hi_wr) begin
                mtimecmp.halves.hi <= cmp_wdata;
            end
        end
    end

    // level, stays high until software moves mtimecmp past mtime
    assign timer_irq = (mtime.full >= mtimecmp.full);

endmodule

//--- hw/mmio_regs.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module mmio_regs (
    input  logic                       clkConstrained,
    input  logic                       rst,
    input  logic                       d_cmd_start,
    input  logic                       d_cmd_write,
    input  logic [31:0]                d_addr,
    input  logic [31:0]                wdata,
    input  logic [31:0]                wmask,
    output logic                       d_cmd_ready,
    output logic [31:0]                rdata,
    output logic                       rdata_valid,
    input  soc_pkg::timer_word_u       cycle,
    input  soc_pkg::timer_word_u       mtime,
    input  soc_pkg::timer_word_u       mtimecmp,
    output logic                       cmp_lo_wr,
    output logic                       cmp_hi_wr,
    output logic [31:0]                cmp_wdata,
    input  logic                       fifo_full,
    input  logic [`TX_FIFO_CNT_W-1:0]  fifo_count,
    output logic                       push,
    output logic [7:0]                 push_data,
    output logic [31:0]                gp,
    output logic [5:0]                 led,
    output logic                       exited
);

    logic        wr;
    logic        rd;
    logic [31:0] gp_next;
    logic [31:0] stat_word;
    logic [31:0] rd_word;
    logic [31:0] cmp_old;

    assign wr = d_cmd_start && d_cmd_write;
    assign rd = d_cmd_start && !d_cmd_write;

    // stall every command while the fifo has no room
    assign d_cmd_ready = !fifo_full;

    // count in the low bits, full flag on top
    always_comb begin
        stat_word     = 32'(fifo_count);
        stat_word[31] = fifo_full;
    end

    always_comb begin
        case (d_addr)
            `ADDR_UART_STAT:   rd_word = stat_word;
            `ADDR_CYCLE_LO:    rd_word = cycle.halves.lo;
            `ADDR_CYCLE_HI:    rd_word = cycle.halves.hi;
            `ADDR_MTIME_LO:    rd_word = mtime.halves.lo;
            `ADDR_MTIME_HI:    rd_word = mtime.halves.hi;
            `ADDR_MTIMECMP_LO: rd_word = mtimecmp.halves.lo;
            `ADDR_MTIMECMP_HI: rd_word = mtimecmp.halves.hi;
            `ADDR_GP:          rd_word = gp;
            `ADDR_EXIT:        rd_word = {31'd0, exited};
            default:           rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clkConstrained) begin
        if (rd) begin
            rdata <= rd_word;
        end
    end

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd;
        end
    end

    // merge the masked bits into whichever compare half is addressed
    assign cmp_lo_wr = wr && (d_addr == `ADDR_MTIMECMP_LO);
    assign cmp_hi_wr = wr && (d_addr == `ADDR_MTIMECMP_HI);
    assign cmp_old   = cmp_hi_wr ? mtimecmp.halves.hi : mtimecmp.halves.lo;
    assign cmp_wdata = (cmp_old & ~wmask) | (wdata & wmask);

    // byte goes straight into the tx fifo
    assign push      = wr && (d_addr == `ADDR_UART_TX);
    assign push_data = wdata[7:0];

    assign gp_next = (wr && (d_addr == `ADDR_GP)) ? ((gp & ~wmask) | (wdata & wmask)) : gp;

    // leds are active low and track gp without lag
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            gp  <= 32'd0;
            led <= 6'h3f;
        end else begin
            gp  <= gp_next;
            led <= ~gp_next[5:0];
        end
    end

    // sticky until reset
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            exited <= 1'b0;
        end else if (wr && (d_addr == `ADDR_EXIT) && wdata[0] && wmask[0]) begin
            exited <= 1'b1;
        end
    end

endmodule

//--- hw/tx_fifo.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module tx_fifo (
    input  logic                      clkConstrained,
    input  logic                      rst,
    input  logic                      push,
    input  logic [7:0]                push_data,
    input  logic                      pop,
    output logic [7:0]                pop_data,
    output logic                      full,
    output logic                      empty,
    output logic [`TX_FIFO_CNT_W-1:0] count
);

    localparam int PTR_W = ($clog2(`TX_FIFO_DEPTH) > 0) ? $clog2(`TX_FIFO_DEPTH) : 1;

    logic [7:0]       mem [`TX_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == `TX_FIFO_CNT_W'(`TX_FIFO_DEPTH));
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // first-word fall-through
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clkConstrained) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module uart_tx (
    input  logic       clkConstrained,
    input  logic       rst,
    input  logic       empty,
    input  logic [7:0] pop_data,
    output logic       pop,
    output logic       line
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]       state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             bit_done;

    assign pop      = (state == ST_IDLE) && !empty;
    assign bit_done = (clk_cnt == BIT_LAST);

    always_ff @(posedge clkConstrained) begin
        if (rst) begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            line    <= 1'b1;
        end else if (state == ST_IDLE) begin
            if (pop) begin
                // start bit goes out right away
                shift   <= pop_data;
                line    <= 1'b0;
                clk_cnt <= '0;
                state   <= ST_START;
            end
        end else if (!bit_done) begin
            clk_cnt <= clk_cnt + 1'b1;
        end else begin
            clk_cnt <= '0;
            case (state)
                ST_START: begin
                    line    <= shift[0];
                    shift   <= shift >> 1;
                    bit_idx <= '0;
                    state   <= ST_DATA;
                end
                ST_DATA: begin
                    if (bit_idx == 3'd7) begin
                        line  <= 1'b1;
                        state <= ST_STOP;
                    end else begin
                        // lsb first
                        line    <= shift[0];
                        shift   <= shift >> 1;
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- hw/soc_top.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module soc_top (
    input  logic        clkConstrained,
    input  logic        rst,
    input  logic        d_cmd_start,
    input  logic        d_cmd_write,
    input  logic [31:0] d_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] wmask,
    output logic        d_cmd_ready,
    output logic [31:0] rdata,
    output logic        rdata_valid,
    output logic        timer_irq,
    output logic        uart_tx,
    output logic [5:0]  led,
    output logic        exited
);

    import soc_pkg::*;

    timer_word_u                cycle;
    timer_word_u                mtime;
    timer_word_u                mtimecmp;
    logic                       cmp_lo_wr;
    logic                       cmp_hi_wr;
    logic [31:0]                cmp_wdata;
    logic                       push;
    logic [7:0]                 push_data;
    logic                       pop;
    logic [7:0]                 pop_data;
    logic                       fifo_full;
    logic                       fifo_empty;
    logic [`TX_FIFO_CNT_W-1:0]  fifo_count;
    logic [31:0]                gp;

    timer_unit u_timer (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .cmp_lo_wr      (cmp_lo_wr),
        .cmp_hi_wr      (cmp_hi_wr),
        .cmp_wdata      (cmp_wdata),
        .cycle          (cycle),
        .mtime          (mtime),
        .mtimecmp       (mtimecmp),
        .timer_irq      (timer_irq)
    );

    mmio_regs u_regs (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .d_cmd_start    (d_cmd_start),
        .d_cmd_write    (d_cmd_write),
        .d_addr         (d_addr),
        .wdata          (wdata),
        .wmask          (wmask),
        .d_cmd_ready    (d_cmd_ready),
        .rdata          (rdata),
        .rdata_valid    (rdata_valid),
        .cycle          (cycle),
        .mtime          (mtime),
        .mtimecmp       (mtimecmp),
        .cmp_lo_wr      (cmp_lo_wr),
        .cmp_hi_wr      (cmp_hi_wr),
        .cmp_wdata      (cmp_wdata),
        .fifo_full      (fifo_full),
        .fifo_count     (fifo_count),
        .push           (push),
        .push_data      (push_data),
        .gp             (gp),
        .led            (led),
        .exited         (exited)
    );

    tx_fifo u_fifo (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .push           (push),
        .push_data      (push_data),
        .pop            (pop),
        .pop_data       (pop_data),
        .full           (fifo_full),
        .empty          (fifo_empty),
        .count          (fifo_count)
    );

    uart_tx u_uart (
        .clkConstrained (clkConstrained),
        .rst            (rst),
        .empty          (fifo_empty),
        .pop_data       (pop_data),
        .pop            (pop),
        .line           (uart_tx)
    );

endmodule

//--- tb/soc_props.sv
`timescale 1ns/1ps

module soc_props (
    input logic clkConstrained,
    input logic rst,
    input logic cmd_start,
    input logic cmd_write,
    input logic cmd_ready,
    input logic rd_valid,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    // one valid pulse per read start, exactly one cycle later
    read_gets_valid: assert property (@(posedge clkConstrained) disable iff (rst)
        cmd_start && !cmd_write |=> rd_valid)
        else begin
            $error("rdata_valid missing one cycle after a read start");
            fail_count++;
        end

    valid_needs_read: assert property (@(posedge clkConstrained) disable iff (rst)
        rd_valid |-> $past(cmd_start && !cmd_write))
        else begin
            $error("rdata_valid without a read start in the cycle before");
            fail_count++;
        end

    start_when_ready: assert property (@(posedge clkConstrained) disable iff (rst)
        cmd_start |-> cmd_ready)
        else begin
            $error("command start while d_cmd_ready is low");
            fail_count++;
        end

    no_push_full: assert property (@(posedge clkConstrained) disable iff (rst)
        push |-> !full)
        else begin
            $error("fifo push while full");
            fail_count++;
        end

    no_pop_empty: assert property (@(posedge clkConstrained) disable iff (rst)
        pop |-> !empty)
        else begin
            $error("fifo pop while empty");
            fail_count++;
        end

endmodule

// command strobes and the push side
bind mmio_regs soc_props u_cmd_props (
    .clkConstrained (clkConstrained),
    .rst            (rst),
    .cmd_start      (d_cmd_start),
    .cmd_write      (d_cmd_write),
    .cmd_ready      (d_cmd_ready),
    .rd_valid       (rdata_valid),
    .push           (push),
    .pop            (1'b0),
    .full           (fifo_full),
    .empty          (1'b0)
);

bind tx_fifo soc_props u_fifo_props (
    .clkConstrained (clkConstrained),
    .rst            (rst),
    .cmd_start      (1'b0),
    .cmd_write      (1'b0),
    .cmd_ready      (1'b1),
    .rd_valid       (1'b0),
    .push           (push),
    .pop            (pop),
    .full           (full),
    .empty          (empty)
);

//--- tb/soc_checker.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module soc_checker (
    input  logic        clkConstrained,
    input  logic        rst,
    input  logic        d_cmd_start,
    input  logic        d_cmd_write,
    input  logic [31:0] d_addr,
    input  logic [31:0] wdata,
    input  logic [31:0] wmask,
    input  logic        d_cmd_ready,
    input  logic [31:0] rdata,
    input  logic        rdata_valid,
    input  logic        timer_irq,
    input  logic        uart_tx,
    input  logic [5:0]  led,
    input  logic        exited,
    output int          read_errs,
    output int          state_errs,
    output int          uart_errs,
    output int          uart_pending
);

    localparam int CPB  = `UART_CLKS_PER_BIT;
    localparam int HALF = `UART_CLKS_PER_BIT / 2;

    logic [63:0] cycle_m;
    logic [63:0] mtime_m;
    logic [63:0] cmp_m;
    logic [31:0] gp_m;
    logic        exited_m;
    int          presc_m;
    int          count_m;
    logic        seen_rst;
    logic        rd_pend;
    logic [31:0] rd_exp;
    logic [31:0] rd_addr;
    logic        rx_busy;
    int          rx_cnt;
    logic [7:0]  rx_byte;
    logic [7:0]  exp_byte;
    logic [7:0]  tx_q[$];

    initial begin
        read_errs    = 0;
        state_errs   = 0;
        uart_errs    = 0;
        uart_pending = 0;
        seen_rst     = 1'b0;
        rx_busy      = 1'b0;
    end

    function automatic logic [31:0] masked(input logic [31:0] old);
        return (old & ~wmask) | (wdata & wmask);
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        logic [31:0] stat;
        stat     = 32'(count_m);
        stat[31] = (count_m == `TX_FIFO_DEPTH);
        case (addr)
            `ADDR_UART_STAT:   return stat;
            `ADDR_CYCLE_LO:    return cycle_m[31:0];
            `ADDR_CYCLE_HI:    return cycle_m[63:32];
            `ADDR_MTIME_LO:    return mtime_m[31:0];
            `ADDR_MTIME_HI:    return mtime_m[63:32];
            `ADDR_MTIMECMP_LO: return cmp_m[31:0];
            `ADDR_MTIMECMP_HI: return cmp_m[63:32];
            `ADDR_GP:          return gp_m;
            `ADDR_EXIT:        return {31'd0, exited_m};
            default:           return 32'd0;
        endcase
    endfunction

    // bit-center sampling of the serial line
    task decode_line;
        int k;
        if (!rx_busy) begin
            if (uart_tx === 1'b0) begin
                // line fell after the serializer popped at the previous edge
                rx_busy = 1'b1;
                rx_cnt  = 0;
                count_m--;
            end
        end else begin
            rx_cnt++;
            k = (rx_cnt - HALF) / CPB;
            if (rx_cnt == HALF && uart_tx !== 1'b0) begin
                uart_errs++;
                $display("uart_tx start bit did not stay low to its center");
            end else if (rx_cnt > HALF && (rx_cnt - HALF) % CPB == 0 && k <= 8) begin
                rx_byte[k-1] = uart_tx;
            end else if (rx_cnt == HALF + 9 * CPB) begin
                rx_busy = 1'b0;
                if (uart_tx !== 1'b1) begin
                    uart_errs++;
                    $display("uart_tx stop bit was not high");
                end
                if (tx_q.size() == 0) begin
                    uart_errs++;
                    $display("uart_tx sent byte %02h that was never written", rx_byte);
                end else begin
                    exp_byte = tx_q.pop_front();
                    if (rx_byte !== exp_byte) begin
                        uart_errs++;
                        $display("** Error uart_tx: expected %02h got %02h", exp_byte, rx_byte);
                    end
                end
            end
        end
    endtask

    task compare_outputs;
        if (timer_irq !== (mtime_m >= cmp_m)) begin
            state_errs++;
            $display("** Error timer_irq: expected %0h got %0h", mtime_m >= cmp_m, timer_irq);
        end
        if (led !== ~gp_m[5:0]) begin
            state_errs++;
            $display("** Error led: expected %02h got %02h", ~gp_m[5:0], led);
        end
        if (exited !== exited_m) begin
            state_errs++;
            $display("** Error exited: expected %0h got %0h", exited_m, exited);
        end
        if (d_cmd_ready !== (count_m != `TX_FIFO_DEPTH)) begin
            state_errs++;
            $display("** Error d_cmd_ready: expected %0h got %0h",
                     count_m != `TX_FIFO_DEPTH, d_cmd_ready);
        end
        if (rdata_valid !== rd_pend) begin
            read_errs++;
            $display("** Error rdata_valid: expected %0h got %0h", rd_pend, rdata_valid);
        end else if (rd_pend && rdata !== rd_exp) begin
            read_errs++;
            $display("** Error rdata: addr %08h expected %08h got %08h", rd_addr, rd_exp, rdata);
        end
    endtask

    task apply_write;
        case (d_addr)
            `ADDR_UART_TX: begin
                tx_q.push_back(wdata[7:0]);
                count_m++;
            end
            `ADDR_MTIMECMP_LO: cmp_m[31:0] = masked(cmp_m[31:0]);
            `ADDR_MTIMECMP_HI: cmp_m[63:32] = masked(cmp_m[63:32]);
            `ADDR_GP:          gp_m = masked(gp_m);
            `ADDR_EXIT: begin
                if (wdata[0] && wmask[0]) begin
                    exited_m = 1'b1;
                end
            end
            default: ;
        endcase
    endtask

    // pre-edge values are compared first, then the model steps
    always @(posedge clkConstrained) begin
        if (rst) begin
            seen_rst = 1'b1;
            cycle_m  = 64'd0;
            mtime_m  = 64'd0;
            cmp_m    = 64'd0;
            gp_m     = 32'd0;
            exited_m = 1'b0;
            presc_m  = 0;
            count_m  = 0;
            rd_pend  = 1'b0;
            rx_busy  = 1'b0;
            tx_q.delete();
        end else if (seen_rst) begin
            decode_line();
            compare_outputs();
            rd_pend = d_cmd_start && !d_cmd_write;
            rd_addr = d_addr;
            rd_exp  = model_read(d_addr);
            if (d_cmd_start && d_cmd_write) begin
                apply_write();
            end
            cycle_m++;
            if (presc_m == `FMAX_MHZ - 1) begin
                presc_m = 0;
                mtime_m++;
            end else begin
                presc_m++;
            end
        end
        uart_pending = tx_q.size();
    end

endmodule

//--- tb/soc_tb.sv
`timescale 1ns/1ps

`include "soc_defs.svh"

module soc_tb;

    localparam int NUM_CMDS      = 400;
    localparam int READY_TIMEOUT = 400;
    localparam int DRAIN_TIMEOUT = 4000;

    logic        clkConstrained;
    logic        rst;
    logic        d_cmd_start;
    logic        d_cmd_write;
    logic [31:0] d_addr;
    logic [31:0] wdata;
    logic [31:0] wmask;
    logic        d_cmd_ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        timer_irq;
    logic        uart_tx;
    logic [5:0]  led;
    logic        exited;
    int          read_errs;
    int          state_errs;
    int          uart_errs;
    int          uart_pending;
    int          prop_errs;
    logic        hung;
    int          seed_val;

    always #20 clkConstrained = ~clkConstrained;

    soc_top DUT (.*);

    soc_checker u_checker (.*);

    function automatic logic [31:0] random_addr();
        case ($urandom_range(0, 11))
            0, 1:    return `ADDR_UART_TX;
            2:       return `ADDR_UART_STAT;
            3:       return `ADDR_CYCLE_LO;
            4:       return `ADDR_CYCLE_HI;
            5:       return `ADDR_MTIME_LO;
            6:       return `ADDR_MTIME_HI;
            7:       return `ADDR_MTIMECMP_LO;
            8:       return `ADDR_MTIMECMP_HI;
            9:       return `ADDR_GP;
            10:      return `ADDR_EXIT;
            default: return 32'hf000_0040 + ($urandom_range(0, 15) << 2);
        endcase
    endfunction

    // ready has settled by the falling edge
    task automatic wait_ready;
        int spins;
        spins = 0;
        @(negedge clkConstrained);
        while (!d_cmd_ready && spins < READY_TIMEOUT) begin
            @(posedge clkConstrained);
            d_cmd_start <= 1'b0;
            @(negedge clkConstrained);
            spins++;
        end
        if (!d_cmd_ready) begin
            $display("timeout: d_cmd_ready stayed low for %0d cycles", READY_TIMEOUT);
            hung = 1'b1;
        end
    endtask

    task automatic send_cmd(input logic write, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] mask, input int idle);
        int gap;
        gap = idle;
        wait_ready();
        if (hung) begin
            return;
        end
        @(posedge clkConstrained);
        d_cmd_start <= 1'b1;
        d_cmd_write <= write;
        d_addr      <= addr;
        wdata       <= data;
        wmask       <= mask;
        // a push reaches the full flag one cycle later
        if (write && addr == `ADDR_UART_TX && gap == 0) begin
            gap = 1;
        end
        if (gap > 0) begin
            @(posedge clkConstrained);
            d_cmd_start <= 1'b0;
            repeat (gap - 1) @(posedge clkConstrained);
        end
    endtask

    initial begin
        logic        write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] mask;
        int          spins;
        clkConstrained = 1'b0;
        rst            = 1'b1;
        d_cmd_start    = 1'b0;
        d_cmd_write    = 1'b0;
        d_addr         = 32'd0;
        wdata          = 32'd0;
        wmask          = 32'd0;
        hung           = 1'b0;
        prop_errs      = 0;
        seed_val       = $urandom(32'h0af50982);
        repeat (3) @(posedge clkConstrained);
        rst <= 1'b0;
        for (int n = 0; n < NUM_CMDS && !hung; n++) begin
            if ($urandom_range(0, 24) == 0) begin
                // burst of tx bytes to fill the fifo
                repeat (6) send_cmd(1'b1, `ADDR_UART_TX, $urandom, 32'hffff_ffff, 0);
            end else begin
                addr  = random_addr();
                write = $urandom_range(0, 1);
                data  = $urandom;
                mask  = ($urandom_range(0, 2) != 0) ? 32'hffff_ffff : $urandom;
                if ((addr == `ADDR_MTIMECMP_LO || addr == `ADDR_MTIMECMP_HI)
                        && $urandom_range(0, 1)) begin
                    data = $urandom_range(0, 600);
                end
                if (addr == `ADDR_EXIT && $urandom_range(0, 3) != 0) begin
                    data[0] = 1'b0;
                end
                if (addr == `ADDR_UART_TX) begin
                    mask = 32'hffff_ffff;
                end
                send_cmd(write, addr, data, mask, $urandom_range(0, 3));
            end
        end
        @(posedge clkConstrained);
        d_cmd_start <= 1'b0;
        spins = 0;
        while (uart_pending != 0 && spins < DRAIN_TIMEOUT) begin
            @(negedge clkConstrained);
            spins++;
        end
        if (uart_pending != 0) begin
            $display("timeout: %0d uart bytes never came out on uart_tx", uart_pending);
            hung = 1'b1;
        end
        repeat (2) @(negedge clkConstrained);
        prop_errs = DUT.u_regs.u_cmd_props.fail_count
                  + DUT.u_fifo.u_fifo_props.fail_count;
        $display("error counts: read %0d, state %0d, uart %0d, assertion %0d",
                 read_errs, state_errs, uart_errs, prop_errs);
        if (!hung && read_errs + state_errs + uart_errs + prop_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- soc_top.f
+incdir+hw
hw/soc_pkg.sv
hw/timer_unit.sv
hw/mmio_regs.sv
hw/tx_fifo.sv
hw/uart_tx.sv
hw/soc_top.sv
tb/soc_props.sv
tb/soc_checker.sv
tb/soc_tb.sv
